// File: dv/tbSdCardCmdSlave.sv
`timescale 1ns/1ps

module tbSdCardCmdSlave;

	import sdCardPkg::*;

	// About 20 commands at up to 200 cycles each stay well below this
	localparam int CYCLE_LIMIT = 5000;

	logic clk = 1'b0;
	logic rst;
	logic cmdIn;
	logic cmdOut;
	logic cmdOe;

	int cycleCount = 0;
	int mismatchCount = 0;
	int protocolCount = 0;
	int endCycle = 0;
	int armBursts = 0;
	int burstCount = 0;
	int capLen = 0;
	int expLen = 0;
	logic respExpected = 1'b0;
	logic prevOe = 1'b0;
	logic burstDone = 1'b0;
	logic burstMatch = 1'b0;
	logic framingGood = 1'b0;
	logic capQ[$];
	logic expQ[$];

	sdCardCmdSlave #(.skipInit(1'b0)) u_sdCardCmdSlave
	(
		.clk(clk),
		.rst(rst),
		.cmdIn(cmdIn),
		.cmdOut(cmdOut),
		.cmdOe(cmdOe)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////
	// Frame helpers
	////////////////////////////////////////

	// CRC7 with x^7 + x^3 + 1, MSB first, starting from zero
	function automatic logic [6:0] crcOf(input logic [119:0] bits, input int len);
		logic [6:0] c;
		logic fb;
		c = 7'd0;
		for (int i = len - 1; i >= 0; i--)
		begin
			fb = bits[i] ^ c[6];
			c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
		end
		return c;
	endfunction

	function automatic logic [31:0] statusWord(input cardStateE s, input bit app);
		logic [31:0] w;
		w = 32'd0;
		w[STATUS_STATE_LSB +: 4] = s;
		w[STATUS_APP_CMD_BIT] = app;
		return w;
	endfunction

	function automatic bit sameBits();
		if (capQ.size() != expQ.size())
			return 1'b0;
		for (int i = 0; i < capQ.size(); i++)
		begin
			if (capQ[i] !== expQ[i])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// R2 protects only the CID, a short response its first 40 bits
	function automatic bit framingOk();
		logic [119:0] covered;
		logic [6:0] got;
		int first;
		int n;
		n = capQ.size();
		if (n != FRAME_BITS && n != LONG_BITS)
			return 1'b0;
		first = (n == LONG_BITS) ? 8 : 0;
		covered = '0;
		got = '0;
		for (int i = first; i < n - 8; i++)
			covered = {covered[118:0], capQ[i]};
		for (int i = n - 8; i < n - 1; i++)
			got = {got[5:0], capQ[i]};
		return (crcOf(covered, n - 8 - first) == got) && capQ[n - 1];
	endfunction

	task automatic pushBits(input logic [127:0] bits, input int len);
		for (int i = len - 1; i >= 0; i--)
			expQ.push_back(bits[i]);
	endtask

	task automatic sendCmd(input logic [5:0] idx, input logic [31:0] arg,
		input bit badCrc, input bit badEnd);
		logic [39:0] head;
		logic [47:0] frameBits;
		head = {2'b01, idx, arg};
		frameBits = {head, crcOf(120'(head), 40) ^ {6'd0, badCrc}, ~badEnd};
		for (int i = 47; i >= 0; i--)
		begin
			@(posedge clk);
			#1 cmdIn = frameBits[i];
		end
		@(posedge clk);
		#1 cmdIn = 1'b1;
		endCycle = cycleCount;
	endtask

	// Waits for the reply to end, or lets the quiet window pass
	task automatic runCmd(input logic [5:0] idx, input logic [31:0] arg,
		input bit badCrc, input bit badEnd);
		armBursts = burstCount;
		sendCmd(idx, arg, badCrc, badEnd);
		if (respExpected)
		begin
			while (!burstDone && (burstCount != armBursts || cycleCount < endCycle + 6))
				@(posedge clk);
			#1 respExpected = 1'b0;
		end
		else
		begin
			repeat (10) @(posedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic shortCmd(input logic [5:0] idx, input logic [31:0] arg,
		input logic [5:0] respIdx, input logic [31:0] respArg);
		logic [39:0] head;
		head = {2'b00, respIdx, respArg};
		expQ.delete();
		pushBits(128'(head), 40);
		pushBits(128'(crcOf(120'(head), 40)), 7);
		pushBits(128'(1'b1), 1);
		respExpected = 1'b1;
		runCmd(idx, arg, 1'b0, 1'b0);
	endtask

	task automatic longCmd(input logic [5:0] idx, input logic [31:0] arg);
		expQ.delete();
		pushBits({8'b00111111, CID_VALUE}, 128);
		pushBits(128'(crcOf(CID_VALUE, 120)), 7);
		pushBits(128'(1'b1), 1);
		respExpected = 1'b1;
		runCmd(idx, arg, 1'b0, 1'b0);
	endtask

	task automatic silentCmd(input logic [5:0] idx, input logic [31:0] arg,
		input bit badCrc, input bit badEnd);
		respExpected = 1'b0;
		runCmd(idx, arg, badCrc, badEnd);
	endtask

	task automatic finishRun(input bit timedOut);
		$display("Errors: %0d mismatches, %0d protocol errors", mismatchCount, protocolCount);
		if (!timedOut && mismatchCount == 0 && protocolCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	////////////////////////////////////////
	// Response capture and checks
	////////////////////////////////////////

	always @(negedge clk)
	begin
		burstDone = 1'b0;
		if (!rst && cmdOe)
		begin
			if (!prevOe)
			begin
				capQ.delete();
				burstCount++;
			end
			capQ.push_back(cmdOut);
		end
		else if (!rst && prevOe)
		begin
			burstDone = 1'b1;
			capLen = capQ.size();
			expLen = expQ.size();
			burstMatch = sameBits();
			framingGood = framingOk();
		end
		prevOe = cmdOe;
	end

	respInTime: assert property (@(posedge clk) disable iff (rst)
		(respExpected && cycleCount == endCycle + 3) |-> (burstCount != armBursts))
	else
	begin
		protocolCount++;
		$display("No response started within 3 cycles of the end bit at %0t", $time);
	end

	noExtraResp: assert property (@(posedge clk) disable iff (rst)
		cmdOe |-> respExpected)
	else
	begin
		protocolCount++;
		$display("Card drove a response that was not expected at %0t", $time);
	end

	burstLength: assert property (@(posedge clk) disable iff (rst)
		burstDone |-> (capLen == expLen))
	else
	begin
		mismatchCount++;
		$display("mismatch at %0t: burst of %0d bits, expected %0d", $time, capLen, expLen);
	end

	burstBits: assert property (@(posedge clk) disable iff (rst)
		burstDone |-> burstMatch)
	else
	begin
		mismatchCount++;
		$display("mismatch at %0t: response bits differ from the expected frame", $time);
	end

	burstFraming: assert property (@(posedge clk) disable iff (rst)
		burstDone |-> framingGood)
	else
	begin
		mismatchCount++;
		$display("mismatch at %0t: response CRC7 or end bit is wrong", $time);
	end

	// Counted between rising edges so the count is stable wherever an edge reads it
	always @(negedge clk)
	begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("Cycle limit of %0d reached before the sequence ended", CYCLE_LIMIT);
			finishRun(1'b1);
		end
	end

	initial
	begin
		cmdIn = 1'b1;
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		repeat (4) @(posedge clk);
		#1;

		silentCmd(goIdle, 32'd0, 1'b0, 1'b0);
		shortCmd(sendIfCond, 32'h000001AA, sendIfCond, 32'h000001AA);

		// Initialization up to stby
		shortCmd(appCmd, 32'd0, appCmd, statusWord(stateIdle, 1'b1));
		shortCmd(sdSendOpCond, 32'h40FF8000, 6'b111111, OCR_VALUE);
		longCmd(allSendCid, 32'd0);
		shortCmd(sendRelAddr, 32'd0, sendRelAddr, {DEFAULT_RCA, 16'h0000});

		silentCmd(selectCard, 32'h12340000, 1'b0, 1'b0);
		shortCmd(selectCard, {DEFAULT_RCA, 16'h0000}, selectCard, statusWord(stateStby, 1'b0));
		shortCmd(sendStatus, {DEFAULT_RCA, 16'h0000}, sendStatus, statusWord(stateTran, 1'b0));
		shortCmd(setBusWidth, 32'h00000002, setBusWidth, statusWord(stateTran, 1'b0));

		// Frames the card must ignore in tran
		silentCmd(allSendCid, 32'd0, 1'b0, 1'b0);
		silentCmd(6'd17, 32'd0, 1'b0, 1'b0);
		silentCmd(6'd60, 32'd0, 1'b0, 1'b0);
		silentCmd(sendStatus, {DEFAULT_RCA, 16'h0000}, 1'b1, 1'b0);
		silentCmd(sendStatus, {DEFAULT_RCA, 16'h0000}, 1'b0, 1'b1);
		shortCmd(sendStatus, {DEFAULT_RCA, 16'h0000}, sendStatus, statusWord(stateTran, 1'b0));

		silentCmd(goIdle, 32'd0, 1'b0, 1'b0);
		silentCmd(sendStatus, {DEFAULT_RCA, 16'h0000}, 1'b0, 1'b0);
		shortCmd(sendIfCond, 32'h000001AA, sendIfCond, 32'h000001AA);

		finishRun(1'b0);
	end

endmodule

// File: flist.f
source/sdCardPkg.sv
source/crc7.sv
source/cmdReceiver.sv
source/cardStateCtrl.sv
source/respTransmitter.sv
source/sdCardCmdSlave.sv
dv/tbSdCardCmdSlave.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tbSdCardCmdSlave -f flist.f -o simv

if ./obj_dir/simv | tee /dev/stderr | grep "Simulation finished: PASS" > /dev/null; then
	exit 0
else
	exit 1
fi

// File: source/cardStateCtrl.sv
`timescale 1ns/1ps

module cardStateCtrl
#(
	parameter bit skipInit = 1'b0
)
(
	input  logic               clk,
	input  logic               rst,
	input  sdCardPkg::cmdFrameT frame,
	input  logic               frameValid,
	input  logic               busy,
	output sdCardPkg::respReqT  resp,
	output logic               respValid
);

	import sdCardPkg::*;

	cardStateE cardState;
	cardStateE nextState;
	logic rcaValid;
	logic nextRcaValid;
	logic rcaMatch;
	logic accept;
	logic respNeeded;
	respKindE respKind;
	logic [31:0] respArg;
	logic [31:0] statusWord;

	assign rcaMatch = (frame.arg[31:16] == DEFAULT_RCA);

	////////////////////////////////////////
	// Command decode
	////////////////////////////////////////

	always_comb
	begin
		accept = 1'b0;
		respNeeded = 1'b1;
		nextState = cardState;
		nextRcaValid = rcaValid;
		respKind = respShort;
		respArg = 32'd0;
		statusWord = 32'd0;
		statusWord[STATUS_STATE_LSB +: $bits(cardStateE)] = cardState;

		case (frame.index)
			goIdle:
			begin
				accept = 1'b1;
				respNeeded = 1'b0;
				nextState = stateIdle;
				nextRcaValid = 1'b0;
			end
			sendIfCond:
			begin
				accept = (cardState == stateIdle);
				respArg = frame.arg;
			end
			appCmd:
			begin
				accept = (cardState != stateReady) && (cardState != stateIdent) &&
					(rcaMatch || !rcaValid);
				respArg = statusWord;
				respArg[STATUS_APP_CMD_BIT] = 1'b1;
			end
			sdSendOpCond:
			begin
				accept = (cardState == stateIdle);
				nextState = stateReady;
				respArg = OCR_VALUE;
			end
			allSendCid:
			begin
				accept = (cardState == stateReady);
				nextState = stateIdent;
				respKind = respLong;
			end
			sendRelAddr:
			begin
				accept = (cardState == stateIdent) || (cardState == stateStby);
				nextState = stateStby;
				nextRcaValid = 1'b1;
				respArg = {DEFAULT_RCA, 16'h0000};
			end
			selectCard:
			begin
				accept = (cardState == stateStby) && rcaMatch;
				nextState = stateTran;
				respArg = statusWord;
			end
			setBusWidth:
			begin
				accept = (cardState == stateTran);
				respArg = statusWord;
			end
			sendStatus:
			begin
				accept = (cardState != stateIdle) && (cardState != stateReady) &&
					(cardState != stateIdent) && rcaMatch;
				respArg = statusWord;
			end
			default:
			begin
				accept = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cardState <= skipInit ? stateTran : stateIdle;
			rcaValid <= skipInit;
			respValid <= 1'b0;
		end
		else
		begin
			respValid <= 1'b0;
			if (frameValid && !busy && accept)
			begin
				cardState <= nextState;
				rcaValid <= nextRcaValid;
				respValid <= respNeeded;
			end
		end
	end

	// R3 and R2 carry the reserved index instead of the command index
	always_ff @(posedge clk)
	begin
		if (frameValid)
		begin
			resp.kind <= respKind;
			resp.index <= (frame.index == sdSendOpCond || respKind == respLong) ?
				R3_INDEX : frame.index;
			resp.arg <= respArg;
		end
	end

	legalCardState: assert property (@(posedge clk) disable iff (rst)
		cardState inside {stateIdle, stateReady, stateIdent, stateStby, stateTran});

endmodule

// File: source/cmdReceiver.sv
`timescale 1ns/1ps

module cmdReceiver
(
	input  logic               clk,
	input  logic               rst,
	input  logic               cmdIn,
	input  logic               busy,
	output sdCardPkg::cmdFrameT frame,
	output logic               frameValid
);

	import sdCardPkg::*;

	typedef enum logic [1:0]
	{
		rxIdle,
		rxTrans,
		rxShift
	} rxStateE;

	rxStateE rxState;
	logic [5:0] bitCnt;
	logic [FRAME_BITS-4:0] shiftReg;
	logic [6:0] crcCalc;
	logic crcShift;
	logic lastBit;

	// The start bit is a zero into a zero register, so the CRC starts at the transmission bit
	assign crcShift = (rxState == rxTrans) ||
		(rxState == rxShift && bitCnt < 6'($bits(cmdFrameT)));
	assign lastBit = (bitCnt == 6'(FRAME_BITS - 3));

	crc7 u_crc7
	(
		.clk(clk),
		.rst(rst),
		.clear(rxState == rxIdle),
		.shiftEn(crcShift),
		.dataBit(cmdIn),
		.crc(crcCalc)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rxState <= rxIdle;
			bitCnt <= 6'd0;
			frameValid <= 1'b0;
		end
		else
		begin
			frameValid <= 1'b0;
			// A response on the line aborts any frame in progress
			if (busy)
			begin
				rxState <= rxIdle;
			end
			else
			begin
				case (rxState)
					rxIdle:
					begin
						if (!cmdIn)
						begin
							rxState <= rxTrans;
						end
					end
					rxTrans:
					begin
						bitCnt <= 6'd0;
						rxState <= cmdIn ? rxShift : rxIdle;
					end
					default:
					begin
						bitCnt <= bitCnt + 6'd1;
						if (lastBit)
						begin
							rxState <= rxIdle;
							frameValid <= cmdIn && (crcCalc == shiftReg[6:0]);
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rxState == rxShift && !lastBit)
		begin
			shiftReg <= {shiftReg[FRAME_BITS-5:0], cmdIn};
		end
	end

	assign frame = shiftReg[FRAME_BITS-4:7];

	// Holds only because a new frame cannot finish before the reply starts
	frameNotDuringResp: assert property (@(posedge clk) disable iff (rst)
		frameValid |-> !busy);

endmodule

// File: source/crc7.sv
`timescale 1ns/1ps

module crc7
(
	input  logic       clk,
	input  logic       rst,
	input  logic       clear,
	input  logic       shiftEn,
	input  logic       dataBit,
	output logic [6:0] crc
);

	logic feedback;

	// Polynomial x^7 + x^3 + 1, MSB first
	assign feedback = dataBit ^ crc[6];

	always_ff @(posedge clk)
	begin
		if (rst || clear)
		begin
			crc <= 7'd0;
		end
		else if (shiftEn)
		begin
			crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
		end
	end

endmodule

// File: source/respTransmitter.sv
`timescale 1ns/1ps

module respTransmitter
(
	input  logic              clk,
	input  logic              rst,
	input  sdCardPkg::respReqT resp,
	input  logic              respValid,
	output logic              cmdOut,
	output logic              cmdOe,
	output logic              busy
);

	import sdCardPkg::*;

	respKindE kindReg;
	logic [LONG_BITS-9:0] dataReg;
	logic [7:0] bitCnt;
	logic [7:0] bodyEnd;
	logic [7:0] lastBit;
	logic [2:0] crcPos;
	logic [6:0] crcCalc;
	logic covered;
	logic txBit;
	logic load;

	assign load = respValid && !cmdOe;
	assign bodyEnd = (kindReg == respLong) ? 8'(LONG_BITS - 8) : 8'(FRAME_BITS - 8);
	assign lastBit = (kindReg == respLong) ? 8'(LONG_BITS - 1) : 8'(FRAME_BITS - 1);
	assign crcPos = 3'(bitCnt - bodyEnd);

	// R2 covers only the CID, a short response covers its whole header
	assign covered = cmdOe && (bitCnt < bodyEnd) &&
		(kindReg == respShort || bitCnt >= 8'd8);

	always_comb
	begin
		if (bitCnt < bodyEnd)
		begin
			txBit = dataReg[LONG_BITS-9];
		end
		else if (bitCnt < lastBit)
		begin
			txBit = crcCalc[3'd6 - crcPos];
		end
		else
		begin
			txBit = 1'b1;
		end
	end

	crc7 u_crc7
	(
		.clk(clk),
		.rst(rst),
		.clear(load),
		.shiftEn(covered),
		.dataBit(dataReg[LONG_BITS-9]),
		.crc(crcCalc)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cmdOe <= 1'b0;
			bitCnt <= 8'd0;
		end
		else if (load)
		begin
			cmdOe <= 1'b1;
			bitCnt <= 8'd0;
		end
		else if (cmdOe)
		begin
			if (bitCnt == lastBit)
			begin
				cmdOe <= 1'b0;
			end
			bitCnt <= bitCnt + 8'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			kindReg <= resp.kind;
			if (resp.kind == respLong)
			begin
				dataReg <= {2'b00, resp.index, CID_VALUE};
			end
			else
			begin
				dataReg <= {2'b00, resp.index, resp.arg, {(LONG_BITS - FRAME_BITS){1'b0}}};
			end
		end
		else if (cmdOe)
		begin
			dataReg <= {dataReg[LONG_BITS-10:0], 1'b0};
		end
	end

	assign cmdOut = cmdOe ? txBit : 1'b1;
	assign busy = cmdOe;

	noRequestWhileBusy: assert property (@(posedge clk) disable iff (rst)
		respValid |-> !busy);

endmodule

// File: source/sdCardCmdSlave.sv
`timescale 1ns/1ps

module sdCardCmdSlave
#(
	parameter bit skipInit = 1'b0
)
(
	input  logic clk,
	input  logic rst,
	input  logic cmdIn,
	output logic cmdOut,
	output logic cmdOe
);

	import sdCardPkg::*;

	cmdFrameT frame;
	logic frameValid;
	respReqT resp;
	logic respValid;
	logic busy;

	cmdReceiver u_cmdReceiver
	(
		.clk(clk),
		.rst(rst),
		.cmdIn(cmdIn),
		.busy(busy),
		.frame(frame),
		.frameValid(frameValid)
	);

	cardStateCtrl #(.skipInit(skipInit)) u_cardStateCtrl
	(
		.clk(clk),
		.rst(rst),
		.frame(frame),
		.frameValid(frameValid),
		.busy(busy),
		.resp(resp),
		.respValid(respValid)
	);

	respTransmitter u_respTransmitter
	(
		.clk(clk),
		.rst(rst),
		.resp(resp),
		.respValid(respValid),
		.cmdOut(cmdOut),
		.cmdOe(cmdOe),
		.busy(busy)
	);

endmodule

// File: source/sdCardPkg.sv
package sdCardPkg;

	////////////////////////////////////////
	// Card states and command indices
	////////////////////////////////////////

	typedef enum logic [3:0]
	{
		stateIdle  = 4'd0,
		stateReady = 4'd1,
		stateIdent = 4'd2,
		stateStby  = 4'd3,
		stateTran  = 4'd4
	} cardStateE;

	// Only the commands the card answers; anything else is ignored
	typedef enum logic [5:0]
	{
		goIdle       = 6'd0,
		allSendCid   = 6'd2,
		sendRelAddr  = 6'd3,
		setBusWidth  = 6'd6,
		selectCard   = 6'd7,
		sendIfCond   = 6'd8,
		sendStatus   = 6'd13,
		sdSendOpCond = 6'd41,
		appCmd       = 6'd55
	} cmdIndexE;

	typedef enum logic
	{
		respShort = 1'b0,
		respLong  = 1'b1
	} respKindE;

	////////////////////////////////////////
	// Frame and response payloads
	////////////////////////////////////////

	typedef struct packed
	{
		logic [5:0]  index;
		logic [31:0] arg;
	} cmdFrameT;

	typedef struct packed
	{
		respKindE    kind;
		logic [5:0]  index;
		logic [31:0] arg;
	} respReqT;

	////////////////////////////////////////
	// Protocol constants
	////////////////////////////////////////

	localparam int FRAME_BITS = 48;
	localparam int LONG_BITS = 136;
	localparam int CID_BITS = 120;
	localparam logic [CID_BITS-1:0] CID_VALUE = 120'h03534453_44434152_44101234_5678C5;
	localparam logic [15:0] DEFAULT_RCA = 16'hAAAA;
	// Busy bit set, 2.7V to 3.6V window
	localparam logic [31:0] OCR_VALUE = 32'h80FF8000;
	localparam logic [5:0] R3_INDEX = 6'b111111;
	localparam int STATUS_APP_CMD_BIT = 5;
	localparam int STATUS_STATE_LSB = 9;

endpackage
